// File: logic/accel_pkg.sv
`default_nettype none

package accel_pkg;

    ////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////
    localparam int PIXEL_W  = 8;
    localparam int WEIGHT_W = 8;
    // Wide enough for four 8x8 products
    localparam int PSUM_W   = 20;
    localparam int QIDX_W   = 2;

    ////////////////////////////////////////
    // Transaction kinds
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        KIND_CONFIG = 2'd0,
        KIND_PIXEL  = 2'd1,
        KIND_CLEAR  = 2'd2,
        // Consumed and dropped
        KIND_RSVD   = 2'd3
    } kind_e;

    ////////////////////////////////////////
    // Payload types
    ////////////////////////////////////////
    typedef logic [PIXEL_W-1:0]  pixel_t;
    typedef logic [WEIGHT_W-1:0] weight_t;
    typedef logic [PSUM_W-1:0]   psum_t;

    // Ingress word, kind in the top bits
    typedef struct packed {
        kind_e               kind;
        logic [QIDX_W-1:0]   quad;
        pixel_t              payload;
    } trans_word_t;

    // Item passed from quad to quad
    typedef struct packed {
        pixel_t pixel;
        psum_t  psum;
    } cascade_t;

endpackage

`default_nettype wire

// File: logic/awp_top.sv
`default_nettype none

module awp_top #(
    parameter int num_quads  = 4,
    parameter int fifo_depth = 4
) (
    input  wire logic                   clk_FAS,
    input  wire logic                   rst,
    input  wire logic                   in_vld,
    output logic                        in_rdy,
    input  wire accel_pkg::trans_word_t in_data,
    output logic                        out_vld,
    input  wire logic                   out_rdy,
    output accel_pkg::psum_t            out_data
);

    import accel_pkg::*;

    ////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////
    // Ingress FIFO to decoder
    logic        in_full;
    logic        in_empty;
    logic        word_pop;
    trans_word_t word;

    // Decoder to weights and chain
    logic                    head_push;
    pixel_t                  head_pixel;
    logic                    head_full;
    logic                    wgt_wr;
    logic [QIDX_W-1:0]       wgt_quad;
    weight_t                 wgt_data;
    logic                    clear;
    logic                    chain_idle;
    weight_t [num_quads-1:0] weights;

    // Chain tail to egress FIFO
    logic  tail_valid;
    psum_t tail_psum;
    logic  eg_full;
    logic  eg_empty;

    assign in_rdy  = !in_full;
    assign out_vld = !eg_empty;

    fifo_fwft #(.payload_t(trans_word_t), .depth(fifo_depth)) u_ingress (
        .clk_FAS (clk_FAS),        .rst   (rst),
        .wr_en   (in_vld && in_rdy), .wr_data (in_data), .full (in_full),
        .rd_en   (word_pop),       .rd_data (word),      .empty (in_empty)
    );

    trans_decode u_decode (
        .clk_FAS    (clk_FAS),    .rst        (rst),
        .word       (word),       .word_valid (!in_empty),
        .head_full  (head_full),  .chain_idle (chain_idle),
        .word_pop   (word_pop),   .head_push  (head_push),
        .head_pixel (head_pixel), .wgt_wr     (wgt_wr),
        .wgt_quad   (wgt_quad),   .wgt_data   (wgt_data),
        .clear      (clear)
    );

    weight_regs #(.num_quads(num_quads)) u_weights (
        .clk_FAS (clk_FAS),  .rst     (rst),
        .wr_en   (wgt_wr),   .wr_quad (wgt_quad),
        .wr_data (wgt_data), .weights (weights)
    );

    quad_chain #(.num_quads(num_quads), .fifo_depth(fifo_depth)) u_chain (
        .clk_FAS    (clk_FAS),    .rst        (rst),
        .clear      (clear),      .weights    (weights),
        .head_push  (head_push),  .head_pixel (head_pixel),
        .head_full  (head_full),  .chain_idle (chain_idle),
        .tail_valid (tail_valid), .tail_psum  (tail_psum),
        .tail_ready (!eg_full)
    );

    // Results queue here while the host holds off
    fifo_fwft #(.payload_t(psum_t), .depth(fifo_depth)) u_egress (
        .clk_FAS (clk_FAS),                 .rst     (rst),
        .wr_en   (tail_valid && !eg_full),  .wr_data (tail_psum), .full (eg_full),
        .rd_en   (out_vld && out_rdy),      .rd_data (out_data),  .empty (eg_empty)
    );

endmodule

`default_nettype wire

// File: logic/conv_quad.sv
`default_nettype none

module conv_quad (
    input  wire logic                   clk_FAS,
    input  wire logic                   rst,
    input  wire logic                   clear,
    input  wire accel_pkg::weight_t     weight,
    input  wire logic                   in_valid,
    input  wire accel_pkg::cascade_t    in_data,
    output logic                        in_ready,
    input  wire logic                   out_ready,
    output logic                        out_valid,
    output accel_pkg::cascade_t         out_data
);

    import accel_pkg::*;

    // Pixel seen one step earlier in the stream
    pixel_t history;
    logic   take;
    psum_t  mac;

    // Register free now or emptied this cycle
    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;

    // Product widened to the psum before the add, wraps modulo 2^20
    assign mac = in_data.psum + psum_t'(weight) * psum_t'(in_data.pixel);

    ////////////////////////////////////////
    // Output register valid
    ////////////////////////////////////////
    always_ff @(posedge clk_FAS) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload, loaded only on a take
    always_ff @(posedge clk_FAS) begin
        if (take) begin
            out_data.psum  <= mac;
            // Older pixel moves on to the next tap
            out_data.pixel <= history;
        end
    end

    ////////////////////////////////////////
    // History pixel
    ////////////////////////////////////////
    always_ff @(posedge clk_FAS) begin
        if (rst || clear) begin
            history <= '0;
        end else if (take) begin
            history <= in_data.pixel;
        end
    end

    // Decoder waits for chain idle before any clear
    a_clear_idle: assert property (@(posedge clk_FAS) disable iff (rst)
        clear |-> (!out_valid && !in_valid))
        else $error("conv_quad: clear with an item in flight");

endmodule

`default_nettype wire

// File: logic/fifo_fwft.sv
`default_nettype none

module fifo_fwft #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  wire logic     clk_FAS,
    input  wire logic     rst,
    input  wire logic     wr_en,
    input  wire payload_t wr_data,
    output logic          full,
    input  wire logic     rd_en,
    output payload_t      rd_data,
    output logic          empty
);

    // Pointer width kept at least one bit for depth 1
    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    // Circular storage
    payload_t mem [depth];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Status straight from the occupancy counter
    assign full  = (count == CNT_W'(depth));
    assign empty = (count == '0);

    // Head word shows without a read
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk_FAS) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////
    always_ff @(posedge clk_FAS) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Wrap by compare since depth need not fill the pointer
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count as is
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // Writers and readers must honour the flags
    a_no_overflow: assert property (@(posedge clk_FAS) disable iff (rst) wr_en |-> !full)
        else $error("fifo_fwft: write while full");
    a_no_underflow: assert property (@(posedge clk_FAS) disable iff (rst) rd_en |-> !empty)
        else $error("fifo_fwft: read while empty");

endmodule

`default_nettype wire

// File: logic/quad_chain.sv
`default_nettype none

module quad_chain #(
    parameter int num_quads  = 4,
    parameter int fifo_depth = 4
) (
    input  wire logic                               clk_FAS,
    input  wire logic                               rst,
    input  wire logic                               clear,
    input  wire accel_pkg::weight_t [num_quads-1:0] weights,
    input  wire logic                               head_push,
    input  wire accel_pkg::pixel_t                  head_pixel,
    output logic                                    head_full,
    output logic                                    chain_idle,
    output logic                                    tail_valid,
    output accel_pkg::psum_t                        tail_psum,
    input  wire logic                               tail_ready
);

    import accel_pkg::*;

    // FIFO k sits in front of quad k
    logic [num_quads-1:0] fifo_wr;
    logic [num_quads-1:0] fifo_full;
    logic [num_quads-1:0] fifo_empty;
    cascade_t             fifo_wdata [num_quads];
    cascade_t             fifo_rdata [num_quads];

    logic [num_quads-1:0] q_in_ready;
    logic [num_quads-1:0] q_out_valid;
    logic [num_quads-1:0] q_out_ready;
    cascade_t             q_out_data [num_quads];

    for (genvar k = 0; k < num_quads; k++) begin : g_quad
        ////////////////////////////////////////
        // Cascade FIFO feed
        ////////////////////////////////////////
        if (k == 0) begin : g_head
            // Fresh pixel starts with a zero sum
            assign fifo_wr[k]    = head_push;
            assign fifo_wdata[k] = '{pixel: head_pixel, psum: '0};
        end else begin : g_link
            assign fifo_wr[k]    = q_out_valid[k-1] && !fifo_full[k];
            assign fifo_wdata[k] = q_out_data[k-1];
        end

        // Downstream room, or the egress side for the last quad
        if (k == num_quads - 1) begin : g_tail
            assign q_out_ready[k] = tail_ready;
        end else begin : g_mid
            assign q_out_ready[k] = !fifo_full[k+1];
        end

        fifo_fwft #(
            .payload_t (cascade_t),
            .depth     (fifo_depth)
        ) u_fifo (
            .clk_FAS (clk_FAS),
            .rst     (rst),
            .wr_en   (fifo_wr[k]),
            .wr_data (fifo_wdata[k]),
            .full    (fifo_full[k]),
            .rd_en   (!fifo_empty[k] && q_in_ready[k]),
            .rd_data (fifo_rdata[k]),
            .empty   (fifo_empty[k])
        );

        conv_quad u_quad (
            .clk_FAS   (clk_FAS),
            .rst       (rst),
            .clear     (clear),
            .weight    (weights[k]),
            .in_valid  (!fifo_empty[k]),
            .in_data   (fifo_rdata[k]),
            .in_ready  (q_in_ready[k]),
            .out_ready (q_out_ready[k]),
            .out_valid (q_out_valid[k]),
            .out_data  (q_out_data[k])
        );
    end

    assign head_full  = fifo_full[0];
    // Tail history pixel has no further use
    assign tail_valid = q_out_valid[num_quads-1];
    assign tail_psum  = q_out_data[num_quads-1].psum;

    // Nothing buffered and nothing held in a stage
    assign chain_idle = (&fifo_empty) && !(|q_out_valid);

endmodule

`default_nettype wire

// File: logic/trans_decode.sv
`default_nettype none

module trans_decode (
    input  wire logic                       clk_FAS,
    input  wire logic                       rst,
    input  wire accel_pkg::trans_word_t     word,
    input  wire logic                       word_valid,
    input  wire logic                       head_full,
    input  wire logic                       chain_idle,
    output logic                            word_pop,
    output logic                            head_push,
    output accel_pkg::pixel_t               head_pixel,
    output logic                            wgt_wr,
    output logic [accel_pkg::QIDX_W-1:0]    wgt_quad,
    output accel_pkg::weight_t              wgt_data,
    output logic                            clear
);

    import accel_pkg::*;

    logic rsvd_drop;

    // Payload goes to both sinks and the strobes pick the taker
    assign head_pixel = word.payload;
    assign wgt_quad   = word.quad;
    assign wgt_data   = word.payload;

    ////////////////////////////////////////
    // Routing and stall rules
    ////////////////////////////////////////
    always_comb begin
        head_push = 1'b0;
        wgt_wr    = 1'b0;
        clear     = 1'b0;
        rsvd_drop = 1'b0;
        if (word_valid) begin
            case (word.kind)
                // Pixels only wait on room at the chain head
                KIND_PIXEL:  head_push = !head_full;
                // Config and Clear hold until older pixels have left the chain
                KIND_CONFIG: wgt_wr    = chain_idle;
                KIND_CLEAR:  clear     = chain_idle;
                default:     rsvd_drop = 1'b1;
            endcase
        end
    end

    // One word leaves the ingress FIFO per action
    assign word_pop = head_push | wgt_wr | clear | rsvd_drop;

    // A stalled word stays at the ingress head unchanged until popped
    a_word_held: assert property (@(posedge clk_FAS) disable iff (rst)
        (word_valid && !word_pop) |=> (word_valid && $stable(word)))
        else $error("trans_decode: pending word changed before its pop");

endmodule

`default_nettype wire

// File: logic/weight_regs.sv
`default_nettype none

module weight_regs #(
    parameter int num_quads = 4
) (
    input  wire logic                                clk_FAS,
    input  wire logic                                rst,
    input  wire logic                                wr_en,
    input  wire logic [accel_pkg::QIDX_W-1:0]        wr_quad,
    input  wire accel_pkg::weight_t                  wr_data,
    output accel_pkg::weight_t [num_quads-1:0]       weights
);

    import accel_pkg::*;

    weight_t [num_quads-1:0] wgt_q;

    // Index falls outside the built chain
    logic out_of_range;
    assign out_of_range = (int'(wr_quad) >= num_quads);

    ////////////////////////////////////////
    // Weight storage
    ////////////////////////////////////////
    always_ff @(posedge clk_FAS) begin
        if (rst) begin
            // Quads contribute nothing until configured
            wgt_q <= '0;
        end else begin
            for (int k = 0; k < num_quads; k++) begin
                if (wr_en && !out_of_range && (int'(wr_quad) == k)) begin
                    wgt_q[k] <= wr_data;
                end
            end
        end
    end

    // Held values steer every quad directly
    assign weights = wgt_q;

    // Host should never address a quad that is not there
    a_quad_in_range: assert property (@(posedge clk_FAS) disable iff (rst)
        wr_en |-> !out_of_range)
        else $error("weight_regs: write to quad %0d, only %0d built", wr_quad, num_quads);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_awp -o sim_tb_awp; then
    echo "Verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/sim_tb_awp)"
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$sim_out"; then
    exit 0
fi
exit 1

// File: sim.f
logic/accel_pkg.sv
logic/fifo_fwft.sv
logic/trans_decode.sv
logic/weight_regs.sv
logic/conv_quad.sv
logic/quad_chain.sv
logic/awp_top.sv
tb/tb_awp.sv

// File: tb/awp_golden.hex
// Entry 0 word count, entry 1 result count, then words {kind, quad, pixel} (12 bits),
// then expected 20-bit results in pixel order, all hex
19
E
800 // Clear
003 // Config quad 0 = 3, single tap
455
4C8
105 // Config quad 1 = 5
207 // Config quad 2 = 7
3FF // Config quad 3 = ff
800 // Clear, full convolution from zero history
401
402
4FF
480
4FF
C12 // Reserved, no result
010 // Config quad 0 = 10 mid-stream
404
800 // Clear
4FF
4FF
4FF
4FF
300 // Config quad 3 = 0
401
F00 // Reserved, no result
402
000FF
00258
00003
0000B
0030E
00788
00E74
106BC
00FF0
014EB
01BE4
119E5
00C04
0071E

// File: tb/tb_awp.sv
`default_nettype none

module tb_awp;

    timeunit 1ns;
    timeprecision 100ps;

    import accel_pkg::*;

    ////////////////////////////////////////
    // Run constants
    ////////////////////////////////////////
    localparam int        CLK_PERIOD   = 8;
    localparam int        RESET_CYCLES = 4;
    // Idle cycles after the last result to flush the chain
    localparam int        DRAIN_CYCLES = 20;
    localparam int        GOLDEN_DEPTH = 64;
    localparam bit [31:0] SEED         = 32'ha486_c948;
    localparam string     GOLDEN_FILE  = "tb/awp_golden.hex";

    // DUT ports
    logic        clk_FAS = 1'b0;
    logic        rst;
    logic        in_vld;
    logic        in_rdy;
    trans_word_t in_data;
    logic        out_vld;
    logic        out_rdy;
    psum_t       out_data;

    // Counts, then stimulus words, then expected results
    logic [19:0] golden [0:GOLDEN_DEPTH-1];

    int          n_count     = 0;
    int          m_count     = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          error_count = 0;
    int          check_count = 0;
    bit          timed_out   = 1'b0;

    awp_top dut0 (
        .clk_FAS  (clk_FAS),
        .rst      (rst),
        .in_vld   (in_vld),
        .in_rdy   (in_rdy),
        .in_data  (in_data),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy),
        .out_data (out_data)
    );

    always #(CLK_PERIOD / 2) clk_FAS = ~clk_FAS;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
        end
    endtask

    // Reset held for a fixed number of cycles with flags watched throughout
    task automatic apply_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk_FAS);
            check_value("out_vld", 32'(out_vld), 32'h0);
            check_value("in_rdy", 32'(in_rdy), 32'h1);
        end
        rst = 1'b0;
        // First cycle out of reset
        @(negedge clk_FAS);
        check_value("out_vld", 32'(out_vld), 32'h0);
        check_value("in_rdy", 32'(in_rdy), 32'h1);
    endtask

    // Streams all words and checks results on the falling edge
    task automatic run_stream();
        int tx_idx;
        int rx_idx;
        bit in_sent;
        tx_idx  = 0;
        rx_idx  = 0;
        in_sent = 1'b0;
        while ((tx_idx < n_count || rx_idx < m_count) && !timed_out) begin
            @(negedge clk_FAS);
            cycle_count++;
            // Word offered last cycle went in on the rising edge
            if (in_sent) begin
                tx_idx++;
                in_vld = 1'b0;
            end
            // Egress ready dropped about a third of the time
            out_rdy = ($urandom % 3) != 0;
            // Registered flags make this transfer certain
            if (out_vld && out_rdy) begin
                if (rx_idx < m_count) begin
                    check_value("out_data", 32'(out_data),
                                32'(golden[2 + n_count + rx_idx]));
                end else begin
                    error_count++;
                    $display("Extra result 0x%h beyond the %0d expected", out_data, m_count);
                end
                rx_idx++;
            end
            // Random gaps but a word once offered is held until taken
            if (!in_vld && tx_idx < n_count && ($urandom % 4) != 0) begin
                in_vld  = 1'b1;
                in_data = trans_word_t'(golden[2 + tx_idx][11:0]);
            end
            in_sent = in_vld && in_rdy;
            if (cycle_count >= cycle_limit) begin
                timed_out = 1'b1;
                error_count++;
                $display("Timeout after %0d cycles: %0d of %0d words sent, %0d of %0d results seen",
                         cycle_count, tx_idx, n_count, rx_idx, m_count);
            end
        end
        in_vld = 1'b0;
    endtask

    // Nothing more may come out once every result is in
    task automatic drain_and_check();
        in_vld  = 1'b0;
        out_rdy = 1'b1;
        repeat (DRAIN_CYCLES) begin
            @(negedge clk_FAS);
            if (out_vld) begin
                error_count++;
                $display("Unexpected result 0x%h after all %0d results arrived", out_data, m_count);
            end
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        bit golden_ok;
        void'($urandom(SEED));
        rst       = 1'b1;
        in_vld    = 1'b0;
        in_data   = '0;
        out_rdy   = 1'b0;

        $readmemh(GOLDEN_FILE, golden);
        golden_ok = !$isunknown(golden[0]) && !$isunknown(golden[1]);
        if (golden_ok) begin
            n_count   = int'(golden[0]);
            m_count   = int'(golden[1]);
            golden_ok = (n_count > 0) && (m_count > 0) && (2 + n_count + m_count <= GOLDEN_DEPTH);
        end
        if (!golden_ok) begin
            error_count++;
            $display("Golden file %s is missing or holds bad counts", GOLDEN_FILE);
        end

        apply_reset();
        if (golden_ok) begin
            // Budget grows with the stream length
            cycle_limit = (n_count + m_count) * 20 + 100;
            run_stream();
            if (!timed_out) begin
                drain_and_check();
            end
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
